//--- src/wallacePkg.sv
package wallacePkg;

    localparam int operandWidth = 16;
    localparam int productWidth = 2 * operandWidth;
    localparam int maxRows = operandWidth;
    localparam int reductionLevels = 6;
    localparam int claGroupWidth = 4;

    typedef logic [operandWidth-1:0] operandT;
    typedef logic [productWidth-1:0] productT;
    typedef logic [$clog2(maxRows+1)-1:0] rowCountT;

    // rows entering each Wallace level, level 0 first.
    // the last level hands two rows to the final adder.
    localparam rowCountT [reductionLevels-1:0] levelRows = {
        rowCountT'(3),
        rowCountT'(4),
        rowCountT'(6),
        rowCountT'(8),
        rowCountT'(11),
        rowCountT'(16)
    };

    // a set of rows between pipeline stages, each aligned to product bit 0.
    // rows above the live count are kept at zero.
    typedef struct packed {
        logic valid;
        productT [maxRows-1:0] rows;
    } rowSetT;

    // the two rows left after the last level, ready for the carry-propagate adder.
    typedef struct packed {
        logic valid;
        productT sum;
        productT carry;
    } sumPairT;

    // row count after one 3:2 level: each group of three gives two rows.
    function automatic int rowsAfter(input int rowsIn);
        int groups;
        groups = rowsIn / 3;
        return 2 * groups + (rowsIn % 3);
    endfunction

endpackage

//--- src/partialProducts.sv
`timescale 1ns/10ps

module partialProducts (
    input  logic                clk,
    input  logic                arstN,
    input  wallacePkg::operandT a,
    input  wallacePkg::operandT b,
    input  logic                inValid,
    output wallacePkg::rowSetT  rows
);

    import wallacePkg::*;

    productT [maxRows-1:0] andRows;
    productT [maxRows-1:0] rowsQ;
    logic                  validQ;

    // row i is b gated by bit i of a, moved up to its weight.
    always_comb begin
        for (int i = 0; i < maxRows; i++) begin
            andRows[i] = (productT'(b) & {productWidth{a[i]}}) << i;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            rowsQ <= andRows;
        end
    end

    assign rows = '{valid: validQ, rows: rowsQ};

endmodule

//--- src/csaLayer.sv
`timescale 1ns/10ps

module csaLayer #(
    parameter int rowsIn = wallacePkg::maxRows
) (
    input  logic               clk,
    input  logic               arstN,
    input  wallacePkg::rowSetT rowsPrev,
    output wallacePkg::rowSetT rowsNext
);

    import wallacePkg::*;

    localparam int groups = rowsIn / 3;
    localparam int rowsOut = rowsAfter(rowsIn);

    productT [maxRows-1:0] reduced;
    productT [maxRows-1:0] rowsQ;
    logic                  validQ;

    // each group of three rows goes through a row of full adders.
    // the sum stays in place and the carry moves up one bit.
    always_comb begin
        productT x;
        productT y;
        productT z;
        reduced = '0;
        for (int g = 0; g < groups; g++) begin
            x = rowsPrev.rows[3*g];
            y = rowsPrev.rows[3*g+1];
            z = rowsPrev.rows[3*g+2];
            reduced[2*g] = x ^ y ^ z;
            reduced[2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
        end

        // rows that do not fill a group move on untouched.
        for (int r = 2 * groups; r < rowsOut; r++) begin
            reduced[r] = rowsPrev.rows[3*groups + r - 2*groups];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= rowsPrev.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rowsPrev.valid) begin
            rowsQ <= reduced;
        end
    end

    assign rowsNext = '{valid: validQ, rows: rowsQ};

endmodule

//--- src/claAdder.sv
`timescale 1ns/10ps

module claAdder (
    input  logic                clk,
    input  logic                arstN,
    input  wallacePkg::sumPairT pair,
    output wallacePkg::productT product,
    output logic                outValid
);

    import wallacePkg::*;

    localparam int groupCount = productWidth / claGroupWidth;

    productT                gen;
    productT                prop;
    productT                carryIn;
    productT                sumNext;
    logic [groupCount-1:0]  groupCarry;

    // carry into bit k of a group, written out as a flat sum of products.
    // k equal to the group width gives the carry out of the group.
    function automatic logic lookahead(
        input logic [claGroupWidth-1:0] g,
        input logic [claGroupWidth-1:0] p,
        input logic                     cin,
        input int                       k
    );
        logic c;
        logic chain;
        c = 1'b0;
        for (int j = 0; j < k; j++) begin
            chain = g[j];
            for (int m = j + 1; m < k; m++) begin
                chain = chain & p[m];
            end
            c = c | chain;
        end
        chain = cin;
        for (int m = 0; m < k; m++) begin
            chain = chain & p[m];
        end
        return c | chain;
    endfunction

    assign gen = pair.sum & pair.carry;
    assign prop = pair.sum ^ pair.carry;

    // groups resolve their carries in parallel and hand one carry up the chain.
    always_comb begin
        groupCarry = '0;
        carryIn = '0;
        for (int grp = 0; grp < groupCount; grp++) begin
            for (int k = 0; k < claGroupWidth; k++) begin
                carryIn[grp*claGroupWidth + k] = lookahead(gen[grp*claGroupWidth +: claGroupWidth],
                    prop[grp*claGroupWidth +: claGroupWidth], groupCarry[grp], k);
            end
            if (grp < groupCount - 1) begin
                groupCarry[grp+1] = lookahead(gen[grp*claGroupWidth +: claGroupWidth],
                    prop[grp*claGroupWidth +: claGroupWidth], groupCarry[grp], claGroupWidth);
            end
        end
    end

    assign sumNext = prop ^ carryIn;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= pair.valid;
        end
    end

    // the product holds until the next valid pair arrives.
    always_ff @(posedge clk) begin
        if (pair.valid) begin
            product <= sumNext;
        end
    end

endmodule

//--- src/wallaceMultiplier.sv
`timescale 1ns/10ps

module wallaceMultiplier (
    input  logic                clk,
    input  logic                arstN,
    input  wallacePkg::operandT a,
    input  wallacePkg::operandT b,
    input  logic                inValid,
    output wallacePkg::productT product,
    output logic                outValid
);

    import wallacePkg::*;

    // levelData[0] comes from the AND array, levelData[i+1] from Wallace level i.
    rowSetT  levelData [reductionLevels+1];
    sumPairT finalPair;

    partialProducts pp0 (
        .clk     (clk),
        .arstN   (arstN),
        .a       (a),
        .b       (b),
        .inValid (inValid),
        .rows    (levelData[0])
    );

    for (genvar lvl = 0; lvl < reductionLevels; lvl++) begin : gLevel
        csaLayer #(
            .rowsIn (int'(levelRows[lvl]))
        ) layer (
            .clk      (clk),
            .arstN    (arstN),
            .rowsPrev (levelData[lvl]),
            .rowsNext (levelData[lvl+1])
        );
    end

    // only two rows survive the last level.
    assign finalPair = '{
        valid: levelData[reductionLevels].valid,
        sum:   levelData[reductionLevels].rows[0],
        carry: levelData[reductionLevels].rows[1]
    };

    claAdder cla0 (
        .clk      (clk),
        .arstN    (arstN),
        .pair     (finalPair),
        .product  (product),
        .outValid (outValid)
    );

endmodule

//--- bench/wallaceMultiplierTb.sv
`timescale 1ns/10ps

module wallaceMultiplierTb;

    import wallacePkg::*;

    localparam int pipeDepth = 8;
    localparam int directedEntries = 17;
    localparam int randomEntries = 40;
    localparam int numEntries = directedEntries + randomEntries;
    localparam int drainTimeout = 50;

    logic    clk = 1'b0;
    logic    arstN;
    operandT a;
    operandT b;
    logic    inValid;
    productT product;
    logic    outValid;

    operandT tableA [numEntries];
    operandT tableB [numEntries];
    logic    tableV [numEntries];
    productT tableP [numEntries];

    productT expQ [$];
    int      issueQ [$];
    productT lastProduct;
    logic    haveLast = 1'b0;
    logic    expValid;
    int      cycle = 0;
    int      issued = 0;
    int      pulses = 0;
    int      seed = 32'h8b30;
    int      productErrors = 0;
    int      validErrors = 0;
    int      countErrors = 0;
    int      timeoutErrors = 0;

    wallaceMultiplier dut0 (
        .clk      (clk),
        .arstN    (arstN),
        .a        (a),
        .b        (b),
        .inValid  (inValid),
        .product  (product),
        .outValid (outValid)
    );

    always #2 clk = ~clk;

    task automatic checkProduct(input productT got, input productT exp, input string what);
        if (got !== exp) begin
            productErrors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            validErrors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp) begin
            countErrors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic setEntry(input int idx, input operandT x, input operandT y, input logic v,
                            input productT p);
        tableA[idx] = x;
        tableB[idx] = y;
        tableV[idx] = v;
        tableP[idx] = p;
    endtask

    // entries with v low are idle cycles whose operands must not show up at the output.
    task automatic buildTable();
        operandT x;
        operandT y;
        setEntry(0, 16'h0000, 16'h0000, 1'b0, 32'h0);
        setEntry(1, 16'h1234, 16'h5678, 1'b0, 32'h0);
        setEntry(2, 16'h0000, 16'h1234, 1'b1, 32'h00000000);
        setEntry(3, 16'hBEEF, 16'h0000, 1'b1, 32'h00000000);
        setEntry(4, 16'hFFFF, 16'hFFFF, 1'b1, 32'hFFFE0001);
        setEntry(5, 16'h0001, 16'hABCD, 1'b1, 32'h0000ABCD);
        setEntry(6, 16'h5A5A, 16'h0001, 1'b1, 32'h00005A5A);
        setEntry(7, 16'h9999, 16'h7777, 1'b0, 32'h0);
        setEntry(8, 16'h3333, 16'h4444, 1'b0, 32'h0);
        setEntry(9, 16'h8000, 16'h8000, 1'b1, 32'h40000000);
        setEntry(10, 16'h0100, 16'h0010, 1'b1, 32'h00001000);
        setEntry(11, 16'h0002, 16'h4000, 1'b1, 32'h00008000);
        setEntry(12, 16'hAAAA, 16'h5555, 1'b1, 32'h38E31C72);
        setEntry(13, 16'h5555, 16'h5555, 1'b1, 32'h1C718E39);
        setEntry(14, 16'hAAAA, 16'hAAAA, 1'b1, 32'h71C638E4);
        setEntry(15, 16'hFFFF, 16'h0001, 1'b1, 32'h0000FFFF);
        setEntry(16, 16'h0000, 16'h0000, 1'b0, 32'h0);
        for (int i = directedEntries; i < numEntries; i++) begin
            x = operandT'($random(seed));
            y = operandT'($random(seed));
            setEntry(i, x, y, 1'b1, productT'(x) * productT'(y));
        end
    endtask

    // outputs are sampled on the falling edge, half a period after they change.
    // a pair driven at rising edge k is taken by the DUT at edge k+1 and seen here after k+8.
    always @(negedge clk) begin
        expValid = 1'b0;
        if (expQ.size() > 0) begin
            expValid = (cycle - issueQ[0] == pipeDepth);
        end
        checkBit(outValid, expValid, "outValid");
        if (outValid === 1'b1) begin
            pulses++;
        end
        if (expValid) begin
            checkProduct(product, expQ[0], "product");
            lastProduct = expQ[0];
            haveLast = 1'b1;
            void'(expQ.pop_front());
            void'(issueQ.pop_front());
        end else if (haveLast) begin
            checkProduct(product, lastProduct, "held product");
        end
        cycle++;
    end

    initial begin
        int waited;
        int totalErrors;
        buildTable();
        a = '0;
        b = '0;
        inValid = 1'b0;
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < numEntries; i++) begin
            @(posedge clk);
            a <= tableA[i];
            b <= tableB[i];
            inValid <= tableV[i];
            if (tableV[i]) begin
                expQ.push_back(tableP[i]);
                issueQ.push_back(cycle);
                issued++;
            end
        end
        @(posedge clk);
        inValid <= 1'b0;

        waited = 0;
        while (expQ.size() > 0 && waited < drainTimeout) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() > 0) begin
            timeoutErrors++;
            $display("Timeout: %0d products went missing after %0d cycles of drain",
                     expQ.size(), drainTimeout);
        end

        // a few quiet cycles catch any late or extra outValid pulse.
        repeat (4) @(negedge clk);
        checkCount(pulses, issued, "outValid pulse count");

        totalErrors = productErrors + validErrors + countErrors + timeoutErrors;
        $display("Errors: product %0d, outValid %0d, count %0d, timeout %0d",
                 productErrors, validErrors, countErrors, timeoutErrors);
        if (totalErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
src/wallacePkg.sv
src/partialProducts.sv
src/csaLayer.sv
src/claAdder.sv
src/wallaceMultiplier.sv
bench/wallaceMultiplierTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= wallaceMultiplierTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= src.f
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILE_LIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

check:
	@test -f $(LOG) || { echo "no log file, use make run first"; exit 1; }
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
